//--- Bender.yml
package:
  name: rd_ig

sources:
  - rd_ig_req_pkg.sv
  - rd_ig_arb_pkg.sv
  - rd_ig_skid_pipe.sv
  - rd_ig_wrr_arb.sv
  - rd_ig_arb.sv
  - rd_ig_split.sv
  - rd_ig_top.sv
  - target: simulation
    files:
      - tb_rd_ig_top.sv

//--- rd_ig_arb.sv
`default_nettype none

module rd_ig_arb #(
  parameter int num_clients = 4,
  parameter int addr_w      = 32,
  parameter int size_w      = 4,
  parameter int id_w        = 2
) (
  input  wire                                        nvdla_core_clk,
  input  wire                                        nvdla_core_rstn,
  input  wire  [num_clients-1:0]                     client_req_valid,
  output wire  [num_clients-1:0]                     client_req_ready,
  input  wire  [num_clients*addr_w-1:0]              client_req_addr,
  input  wire  [num_clients*size_w-1:0]              client_req_size,
  input  wire  [num_clients*rd_ig_arb_pkg::wt_w-1:0] client_rd_wt,
  output logic                                       arb2spt_req_valid,
  input  wire                                        arb2spt_req_ready,
  output logic [addr_w-1:0]                          arb2spt_req_addr,
  output logic [size_w-1:0]                          arb2spt_req_size,
  output logic [id_w-1:0]                            arb2spt_req_id
);

  wire  [num_clients-1:0] src_vld;
  logic [num_clients-1:0] src_rdy;
  wire  [addr_w-1:0]      src_addr [num_clients];
  wire  [size_w-1:0]      src_size [num_clients];
  wire  [num_clients-1:0] gnt;
  logic                   gnt_busy;

  // ========================================
  // per-client pipes
  // ========================================
  for (genvar i = 0; i < num_clients; i++) begin : g_pipe
    rd_ig_skid_pipe #(
      .addr_w (addr_w),
      .size_w (size_w)
    ) u_pipe (
      .nvdla_core_clk  (nvdla_core_clk),
      .nvdla_core_rstn (nvdla_core_rstn),
      .in_valid        (client_req_valid[i]),
      .in_ready        (client_req_ready[i]),
      .in_addr         (client_req_addr[i*addr_w +: addr_w]),
      .in_size         (client_req_size[i*size_w +: size_w]),
      .src_vld         (src_vld[i]),
      .src_rdy         (src_rdy[i]),
      .src_addr        (src_addr[i]),
      .src_size        (src_size[i])
    );
    assign src_rdy[i] = gnt[i] && arb2spt_req_ready;  // pop only the granted pipe
  end

  assign gnt_busy = !arb2spt_req_ready;

  rd_ig_wrr_arb #(
    .num_clients (num_clients)
  ) u_wrr (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .req             (src_vld),
    .wt              (client_rd_wt),
    .gnt_busy        (gnt_busy),
    .gnt             (gnt)
  );

  // ========================================
  // payload select and id encode
  // ========================================
  always_comb begin
    arb2spt_req_addr = '0;
    arb2spt_req_size = '0;
    arb2spt_req_id   = '0;
    for (int i = 0; i < num_clients; i++) begin
      if (gnt[i]) begin  // grant is one-hot
        arb2spt_req_addr = src_addr[i];
        arb2spt_req_size = src_size[i];
        arb2spt_req_id   = id_w'(i);
      end
    end
  end

  assign arb2spt_req_valid = |gnt;

endmodule : rd_ig_arb

`default_nettype wire

//--- rd_ig_arb_pkg.sv
`default_nettype none

// ========================================
// arbitration definitions
// ========================================
package rd_ig_arb_pkg;

  localparam int wt_w = 8;  // per-client weight width

  // arbiter fsm
  typedef enum logic {
    arb_idle,  // no grant held
    arb_hold   // grant frozen by back-pressure or weight credit left
  } arb_state_e;

endpackage : rd_ig_arb_pkg

`default_nettype wire

//--- rd_ig_req_pkg.sv
`default_nettype none

// ========================================
// request format for the read ingress path
// ========================================
package rd_ig_req_pkg;

  localparam int atom_bytes  = 32;                   // address granule in bytes
  localparam int block_atoms = 8;                    // 256-byte block
  localparam int atom_shift  = $clog2(atom_bytes);   // byte offset bits inside an atom
  localparam int blk_atom_w  = $clog2(block_atoms);  // atom index bits inside a block

  // splitter fsm
  typedef enum logic {
    spt_idle,  // nothing held
    spt_busy   // chunks of the held request still to go
  } split_state_e;

endpackage : rd_ig_req_pkg

`default_nettype wire

//--- rd_ig_skid_pipe.sv
`default_nettype none

module rd_ig_skid_pipe #(
  parameter int addr_w = 32,
  parameter int size_w = 4
) (
  input  wire               nvdla_core_clk,
  input  wire               nvdla_core_rstn,
  input  wire               in_valid,
  output logic              in_ready,
  input  wire  [addr_w-1:0] in_addr,
  input  wire  [size_w-1:0] in_size,
  output logic              src_vld,
  input  wire               src_rdy,
  output logic [addr_w-1:0] src_addr,
  output logic [size_w-1:0] src_size
);

  localparam int pd_w = addr_w + size_w;  // {addr, size}

  logic            pipe_valid;
  logic            pipe_ready;      // registered copy of skid_ready
  logic            pipe_ready_bc;
  logic [pd_w-1:0] pipe_data;
  logic            skid_valid;
  logic            skid_ready;
  logic            skid_ready_flop;
  logic            skid_catch;
  logic [pd_w-1:0] skid_data;
  logic [pd_w-1:0] out_data;

  // ========================================
  // bubble-collapse stage
  // ========================================
  assign pipe_ready_bc = pipe_ready || !pipe_valid;  // empty stage always takes
  assign in_ready      = pipe_ready_bc;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      pipe_valid <= 1'b0;
    end else begin
      pipe_valid <= pipe_ready_bc ? in_valid : 1'b1;  // stalled stage keeps its item
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (pipe_ready_bc && in_valid) begin
      pipe_data <= {in_addr, in_size};
    end
  end

  // ========================================
  // skid stage
  // ========================================
  // catch the item that slips in while ready is still the old flop value
  assign skid_catch = pipe_valid && skid_ready_flop && !src_rdy;
  assign skid_ready = skid_valid ? src_rdy : !skid_catch;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      skid_valid      <= 1'b0;
      skid_ready_flop <= 1'b1;
      pipe_ready      <= 1'b1;  // ready high out of reset
    end else begin
      skid_valid      <= skid_valid ? !src_rdy : skid_catch;
      skid_ready_flop <= skid_ready;
      pipe_ready      <= skid_ready;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (skid_catch) begin
      skid_data <= pipe_data;
    end
  end

  // skid flop picks the source of the output
  assign src_vld  = skid_ready_flop ? pipe_valid : skid_valid;
  assign out_data = skid_ready_flop ? pipe_data : skid_data;
  assign src_addr = out_data[pd_w-1:size_w];
  assign src_size = out_data[size_w-1:0];

  a_ctrl_no_x: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    !$isunknown({in_valid, in_ready, src_vld, src_rdy}));

  // client keeps valid and payload until it is taken
  a_in_hold: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (in_valid && !in_ready) |=> (in_valid && $stable(in_addr) && $stable(in_size)));

endmodule : rd_ig_skid_pipe

`default_nettype wire

//--- rd_ig_split.sv
`default_nettype none

module rd_ig_split #(
  parameter int addr_w = 32,
  parameter int size_w = 4,
  parameter int id_w   = 2
) (
  input  wire               nvdla_core_clk,
  input  wire               nvdla_core_rstn,
  input  wire               arb2spt_req_valid,
  output logic              arb2spt_req_ready,
  input  wire  [addr_w-1:0] arb2spt_req_addr,
  input  wire  [size_w-1:0] arb2spt_req_size,
  input  wire  [id_w-1:0]   arb2spt_req_id,
  output logic              dma_rd_req_valid,
  input  wire               dma_rd_req_ready,
  output logic [addr_w-1:0] dma_rd_req_addr,
  output logic [size_w-1:0] dma_rd_req_size,
  output logic [id_w-1:0]   dma_rd_req_id
);

  import rd_ig_req_pkg::*;

  localparam int cnt_w = size_w + 1;  // atom count, not count minus one

  split_state_e          state;
  logic [addr_w-1:0]     cur_addr;     // next chunk start
  logic [cnt_w-1:0]      rem_atoms;    // atoms not yet sent
  logic [id_w-1:0]       cur_id;
  logic [blk_atom_w-1:0] blk_pos;
  logic [cnt_w-1:0]      to_blk_end;
  logic [cnt_w-1:0]      chunk_atoms;
  logic                  last_chunk;
  logic                  chunk_xfer;
  logic                  req_xfer;

  // ========================================
  // chunk sizing
  // ========================================
  assign blk_pos     = cur_addr[atom_shift +: blk_atom_w];  // atom slot in block
  assign to_blk_end  = cnt_w'(block_atoms) - cnt_w'(blk_pos);
  assign chunk_atoms = (rem_atoms < to_blk_end) ? rem_atoms : to_blk_end;
  assign last_chunk  = (chunk_atoms == rem_atoms);

  assign dma_rd_req_valid = (state == spt_busy);
  assign dma_rd_req_addr  = cur_addr;
  assign dma_rd_req_size  = size_w'(chunk_atoms - 1'b1);
  assign dma_rd_req_id    = cur_id;

  assign chunk_xfer = dma_rd_req_valid && dma_rd_req_ready;
  // take a new request when empty or as the last chunk leaves
  assign arb2spt_req_ready = (state == spt_idle) || (chunk_xfer && last_chunk);
  assign req_xfer          = arb2spt_req_valid && arb2spt_req_ready;

  // ========================================
  // fsm and chunk state
  // ========================================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      state <= spt_idle;
    end else if (req_xfer) begin
      state <= spt_busy;
    end else if (chunk_xfer && last_chunk) begin
      state <= spt_idle;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (req_xfer) begin
      cur_addr  <= arb2spt_req_addr;
      rem_atoms <= cnt_w'(arb2spt_req_size) + 1'b1;
      cur_id    <= arb2spt_req_id;
    end else if (chunk_xfer) begin
      cur_addr  <= cur_addr + (addr_w'(chunk_atoms) << atom_shift);  // step by bytes
      rem_atoms <= rem_atoms - chunk_atoms;
    end
  end

  // no chunk runs past a 256-byte block
  a_no_blk_cross: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    dma_rd_req_valid |->
      (int'(dma_rd_req_addr[atom_shift +: blk_atom_w]) + int'(dma_rd_req_size) < block_atoms));

endmodule : rd_ig_split

`default_nettype wire

//--- rd_ig_top.sv
`default_nettype none

module rd_ig_top #(
  parameter int num_clients = 4,
  parameter int addr_w      = 32,
  parameter int size_w      = 4,
  parameter int id_w        = 2
) (
  input  wire                                        nvdla_core_clk,
  input  wire                                        nvdla_core_rstn,
  input  wire  [num_clients-1:0]                     client_req_valid,
  output wire  [num_clients-1:0]                     client_req_ready,
  input  wire  [num_clients*addr_w-1:0]              client_req_addr,
  input  wire  [num_clients*size_w-1:0]              client_req_size,
  input  wire  [num_clients*rd_ig_arb_pkg::wt_w-1:0] client_rd_wt,
  output wire                                        dma_rd_req_valid,
  input  wire                                        dma_rd_req_ready,
  output wire  [addr_w-1:0]                          dma_rd_req_addr,
  output wire  [size_w-1:0]                          dma_rd_req_size,
  output wire  [id_w-1:0]                            dma_rd_req_id
);

  // arbiter to splitter
  wire              arb2spt_req_valid;
  wire              arb2spt_req_ready;
  wire [addr_w-1:0] arb2spt_req_addr;
  wire [size_w-1:0] arb2spt_req_size;
  wire [id_w-1:0]   arb2spt_req_id;

  rd_ig_arb #(
    .num_clients (num_clients),
    .addr_w      (addr_w),
    .size_w      (size_w),
    .id_w        (id_w)
  ) u_arb (
    .nvdla_core_clk    (nvdla_core_clk),
    .nvdla_core_rstn   (nvdla_core_rstn),
    .client_req_valid  (client_req_valid),
    .client_req_ready  (client_req_ready),
    .client_req_addr   (client_req_addr),
    .client_req_size   (client_req_size),
    .client_rd_wt      (client_rd_wt),
    .arb2spt_req_valid (arb2spt_req_valid),
    .arb2spt_req_ready (arb2spt_req_ready),
    .arb2spt_req_addr  (arb2spt_req_addr),
    .arb2spt_req_size  (arb2spt_req_size),
    .arb2spt_req_id    (arb2spt_req_id)
  );

  rd_ig_split #(
    .addr_w (addr_w),
    .size_w (size_w),
    .id_w   (id_w)
  ) u_split (
    .nvdla_core_clk    (nvdla_core_clk),
    .nvdla_core_rstn   (nvdla_core_rstn),
    .arb2spt_req_valid (arb2spt_req_valid),
    .arb2spt_req_ready (arb2spt_req_ready),
    .arb2spt_req_addr  (arb2spt_req_addr),
    .arb2spt_req_size  (arb2spt_req_size),
    .arb2spt_req_id    (arb2spt_req_id),
    .dma_rd_req_valid  (dma_rd_req_valid),
    .dma_rd_req_ready  (dma_rd_req_ready),
    .dma_rd_req_addr   (dma_rd_req_addr),
    .dma_rd_req_size   (dma_rd_req_size),
    .dma_rd_req_id     (dma_rd_req_id)
  );

endmodule : rd_ig_top

`default_nettype wire

//--- rd_ig_wrr_arb.sv
`default_nettype none

module rd_ig_wrr_arb #(
  parameter int num_clients = 4
) (
  input  wire                                      nvdla_core_clk,
  input  wire                                      nvdla_core_rstn,
  input  wire  [num_clients-1:0]                   req,
  input  wire  [num_clients*rd_ig_arb_pkg::wt_w-1:0] wt,
  input  wire                                      gnt_busy,
  output logic [num_clients-1:0]                   gnt
);

  import rd_ig_arb_pkg::*;

  localparam int cw = (num_clients > 1) ? $clog2(num_clients) : 1;

  arb_state_e      state;
  logic [cw-1:0]   ptr;         // first client to look at
  logic [cw-1:0]   held_idx;    // client owning the held grant
  logic [wt_w-1:0] credit;      // transfers left for held client
  logic            pick_vld;
  logic [cw-1:0]   pick_idx;
  logic            hold_hit;
  logic            gnt_vld;
  logic [cw-1:0]   sel;
  logic [wt_w-1:0] sel_wt;
  logic [wt_w-1:0] cur_credit;
  logic [cw-1:0]   next_ptr;

  // ========================================
  // round-robin search
  // ========================================
  always_comb begin
    int idx;
    pick_vld = 1'b0;
    pick_idx = '0;
    for (int i = 0; i < num_clients; i++) begin
      idx = (int'(ptr) + i) % num_clients;  // wrap past the last client
      if (!pick_vld && req[idx]) begin
        pick_vld = 1'b1;
        pick_idx = cw'(idx);
      end
    end
  end

  // held grant wins while its client still asks
  assign hold_hit = (state == arb_hold) && req[held_idx];
  assign gnt_vld  = hold_hit || pick_vld;
  assign sel      = hold_hit ? held_idx : pick_idx;
  assign gnt      = gnt_vld ? (num_clients'(1) << sel) : '0;

  // weight 0 counts as 1
  assign sel_wt     = wt[sel*wt_w +: wt_w];
  assign cur_credit = hold_hit ? credit : ((sel_wt == '0) ? wt_w'(1) : sel_wt);
  assign next_ptr   = (sel == cw'(num_clients - 1)) ? '0 : sel + 1'b1;

  // ========================================
  // grant state
  // ========================================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      state    <= arb_idle;
      ptr      <= '0;
      held_idx <= '0;
      credit   <= '0;
    end else if (!gnt_vld) begin
      state <= arb_idle;
    end else if (gnt_busy) begin
      state    <= arb_hold;  // freeze until the transfer
      held_idx <= sel;
      credit   <= cur_credit;
    end else if (cur_credit > wt_w'(1)) begin
      state    <= arb_hold;  // more back-to-back grants allowed
      held_idx <= sel;
      credit   <= cur_credit - 1'b1;
      ptr      <= next_ptr;  // search resumes past it once it stops asking
    end else begin
      state <= arb_idle;
      ptr   <= next_ptr;     // move past the served client
    end
  end

  a_gnt_legal: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    $onehot0(gnt) && ((gnt & ~req) == '0));

  // relies on the pipes keeping src_vld while stalled
  a_gnt_frozen: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (gnt_vld && gnt_busy) |=> (gnt == $past(gnt)));

endmodule : rd_ig_wrr_arb

`default_nettype wire

//--- sim.f
rd_ig_req_pkg.sv
rd_ig_arb_pkg.sv
rd_ig_skid_pipe.sv
rd_ig_wrr_arb.sv
rd_ig_arb.sv
rd_ig_split.sv
rd_ig_top.sv
tb_rd_ig_top.sv

//--- tb_rd_ig_top.sv
`default_nettype none

module tb_rd_ig_top;

  timeunit 1ns;
  timeprecision 1ps;

  import rd_ig_req_pkg::*;
  import rd_ig_arb_pkg::*;

  localparam int num_clients = 4;
  localparam int addr_w      = 32;
  localparam int size_w      = 4;
  localparam int id_w        = 2;
  localparam int drain_limit = 3000;  // cycles per test

  typedef struct packed {
    logic [7:0]  test;
    logic [7:0]  client;
    logic [31:0] addr;
    logic [7:0]  size;    // atoms minus one
    logic [7:0]  nchunk;  // chunks worked out by hand
  } ent_t;

  localparam ent_t tbl [12] = '{
    '{8'd2, 8'd0, 32'h1000_0000, 8'd0,  8'd1},
    '{8'd2, 8'd1, 32'h0000_00e0, 8'd3,  8'd2},  // last atom of a block
    '{8'd2, 8'd2, 32'h0000_0040, 8'd15, 8'd3},
    '{8'd2, 8'd3, 32'h0000_0300, 8'd7,  8'd1},  // exactly one block
    '{8'd2, 8'd0, 32'h1234_5660, 8'd9,  8'd2},
    '{8'd2, 8'd1, 32'h0000_0fe0, 8'd15, 8'd3},
    '{8'd3, 8'd2, 32'h0000_1020, 8'd2,  8'd1},
    '{8'd3, 8'd3, 32'h0000_20c0, 8'd6,  8'd2},
    '{8'd3, 8'd0, 32'h0000_3000, 8'd15, 8'd2},
    '{8'd3, 8'd1, 32'h0000_40a0, 8'd12, 8'd3},
    '{8'd3, 8'd2, 32'h0000_50e0, 8'd8,  8'd2},
    '{8'd3, 8'd3, 32'h0000_6020, 8'd4,  8'd1}
  };

  logic                          nvdla_core_clk;
  logic                          nvdla_core_rstn;
  logic [num_clients-1:0]        client_req_valid;
  wire  [num_clients-1:0]        client_req_ready;
  logic [num_clients*addr_w-1:0] client_req_addr;
  logic [num_clients*size_w-1:0] client_req_size;
  logic [num_clients*wt_w-1:0]   client_rd_wt;
  wire                           dma_rd_req_valid;
  logic                          dma_rd_req_ready;
  wire  [addr_w-1:0]             dma_rd_req_addr;
  wire  [size_w-1:0]             dma_rd_req_size;
  wire  [id_w-1:0]               dma_rd_req_id;

  // per-client request rows and expected chunk rows
  logic [addr_w-1:0] req_addr [num_clients][16];
  int                req_size [num_clients][16];
  int                req_cnt  [num_clients];
  int                sent     [num_clients];  // requests taken by the dut
  bit                taken    [num_clients];  // valid and ready seen before the edge
  logic [addr_w-1:0] exp_addr [num_clients][32];
  int                exp_size [num_clients][32];
  bit                exp_last [num_clients][32];
  int                exp_tot  [num_clients][32];
  int                exp_wr   [num_clients];
  int                exp_rd   [num_clients];
  int                atom_sum [num_clients];
  int                ord_id   [64];             // client of each finished request
  int                ord_n;
  bit                run;
  bit                rdy_rand;
  bit                timed_out;
  logic [31:0]       lfsr;
  logic              mon_v;
  logic              mon_r;
  logic [addr_w-1:0] mon_addr;
  logic [size_w-1:0] mon_size;
  logic [id_w-1:0]   mon_id;
  int                errors;
  int                checks;
  int                err_base;

  rd_ig_top #(
    .num_clients (num_clients),
    .addr_w      (addr_w),
    .size_w      (size_w),
    .id_w        (id_w)
  ) rd_ig_top_i (.*);

  always #5 nvdla_core_clk = ~nvdla_core_clk;

  // galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // ========================================
  // reference chunking
  // ========================================
  task automatic add_request(input int c, input logic [addr_w-1:0] addr, input int size,
                             input int exp_n);
    logic [addr_w-1:0] a;
    int rem;
    int room;
    int len;
    int n;
    req_addr[c][req_cnt[c]] = addr;
    req_size[c][req_cnt[c]] = size;
    req_cnt[c]++;
    a   = addr;
    rem = size + 1;
    n   = 0;
    while (rem > 0) begin
      room = block_atoms - int'((a / atom_bytes) % block_atoms);  // atoms to block end
      len  = (rem < room) ? rem : room;
      exp_addr[c][exp_wr[c]] = a;
      exp_size[c][exp_wr[c]] = len - 1;
      exp_last[c][exp_wr[c]] = (len == rem);
      exp_tot[c][exp_wr[c]]  = size + 1;
      exp_wr[c]++;
      a   = a + addr_w'(len * atom_bytes);
      rem = rem - len;
      n++;
    end
    if (exp_n >= 0 && n != exp_n) begin
      $display("table row for client %0d at %h lists %0d chunks but the rule gives %0d",
               c, addr, exp_n, n);
      errors++;
    end
  endtask

  // ========================================
  // memory-side monitor and client drivers
  // ========================================
  task automatic check_chunk();
    int c;
    int rd;
    c  = int'(mon_id);
    rd = exp_rd[c];
    checks++;
    if (rd == exp_wr[c]) begin
      $display("chunk at %h for client %0d was not expected", mon_addr, c);
      errors++;
    end else begin
      if (mon_addr !== exp_addr[c][rd]) begin
        $display("FAILED dma_rd_req_addr client %0d: got %h expected %h",
                 c, mon_addr, exp_addr[c][rd]);
        errors++;
      end
      if (mon_size !== size_w'(exp_size[c][rd])) begin
        $display("FAILED dma_rd_req_size client %0d: got %h expected %h",
                 c, mon_size, exp_size[c][rd]);
        errors++;
      end
      if (int'((mon_addr / atom_bytes) % block_atoms) + int'(mon_size) >= block_atoms) begin
        $display("chunk at %h with size %h runs past a 256-byte block", mon_addr, mon_size);
        errors++;
      end
      atom_sum[c] += int'(mon_size) + 1;
      if (exp_last[c][rd]) begin  // whole request done
        if (atom_sum[c] != exp_tot[c][rd]) begin
          $display("FAILED dma_rd_req_size atom sum client %0d: got %h expected %h",
                   c, atom_sum[c], exp_tot[c][rd]);
          errors++;
        end
        atom_sum[c] = 0;
        if (ord_n < 64) begin
          ord_id[ord_n] = c;
          ord_n++;
        end
      end
      exp_rd[c] = rd + 1;
    end
  endtask

  task automatic check_stall();
    checks++;
    if (!dma_rd_req_valid) begin
      $display("dma_rd_req_valid dropped while its chunk was stalled");
      errors++;
    end else if ({dma_rd_req_addr, dma_rd_req_size, dma_rd_req_id} !==
                 {mon_addr, mon_size, mon_id}) begin
      $display("FAILED dma_rd_req payload under stall: got %h expected %h",
               {dma_rd_req_addr, dma_rd_req_size, dma_rd_req_id}, {mon_addr, mon_size, mon_id});
      errors++;
    end
  endtask

  task automatic drive_client(input int c);
    if (taken[c]) sent[c]++;  // went in at the edge just passed
    if (run && sent[c] < req_cnt[c]) begin
      client_req_valid[c]                 = 1'b1;
      client_req_addr[c*addr_w +: addr_w] = req_addr[c][sent[c]];
      client_req_size[c*size_w +: size_w] = size_w'(req_size[c][sent[c]]);
      taken[c]                            = client_req_ready[c];  // ready is a flop
    end else begin
      client_req_valid[c] = 1'b0;
      taken[c]            = 1'b0;
    end
  endtask

  always @(negedge nvdla_core_clk) begin
    if (mon_v && mon_r) begin
      check_chunk();
    end else if (mon_v) begin
      check_stall();
    end
    if (rdy_rand) begin
      lfsr             = lfsr_next(lfsr);  // one step per ready bit
      dma_rd_req_ready = lfsr[0];
    end else begin
      dma_rd_req_ready = 1'b1;
    end
    mon_v    = dma_rd_req_valid;
    mon_r    = dma_rd_req_ready;
    mon_addr = dma_rd_req_addr;
    mon_size = dma_rd_req_size;
    mon_id   = dma_rd_req_id;
    for (int c = 0; c < num_clients; c++) begin
      drive_client(c);
    end
  end

  // ========================================
  // test sequencing
  // ========================================
  task automatic start_test(input int w0);
    @(negedge nvdla_core_clk);
    err_base = errors;
    ord_n    = 0;
    for (int c = 0; c < num_clients; c++) begin
      client_rd_wt[c*wt_w +: wt_w] = wt_w'((c == 0) ? w0 : 1);
      req_cnt[c]  = 0;
      sent[c]     = 0;
      exp_wr[c]   = 0;
      exp_rd[c]   = 0;
      atom_sum[c] = 0;
    end
  endtask

  task automatic run_test(input bit rnd);
    int cyc;
    bit done;
    @(posedge nvdla_core_clk);
    run      = 1'b1;
    rdy_rand = rnd;
    cyc      = 0;
    done     = 1'b0;
    while (!done && !timed_out) begin
      @(posedge nvdla_core_clk);
      cyc++;
      done = 1'b1;
      for (int c = 0; c < num_clients; c++) begin
        if (sent[c] != req_cnt[c] || exp_rd[c] != exp_wr[c]) done = 1'b0;
      end
      if (!done && cyc >= drain_limit) begin
        timed_out = 1'b1;
        $display("timeout: requests did not drain within %0d cycles", drain_limit);
      end
    end
    run      = 1'b0;
    rdy_rand = 1'b0;
    @(negedge nvdla_core_clk);
    checks++;
    if (!timed_out && dma_rd_req_valid) begin
      $display("dma_rd_req_valid still high after every expected chunk arrived");
      errors++;
    end
  endtask

  // any num_clients requests in a row come from distinct clients
  task automatic check_rotation();
    logic [num_clients-1:0] seen;
    for (int i = 0; i + num_clients <= ord_n; i++) begin
      seen = '0;
      for (int j = i; j < i + num_clients; j++) seen[ord_id[j]] = 1'b1;
      checks++;
      if (seen != '1) begin
        $display("FAILED dma_rd_req_id rotation at request %0d: got %h expected %h",
                 i, seen, {num_clients{1'b1}});
        errors++;
      end
    end
  endtask

  task automatic check_weights(input int w0);
    int win;
    int cnt;
    win = w0 + num_clients - 1;  // one full weighted rotation
    for (int i = 0; i + win <= ord_n; i++) begin
      cnt = 0;
      for (int j = i; j < i + win; j++) if (ord_id[j] == 0) cnt++;
      checks++;
      if (cnt != w0) begin
        $display("FAILED dma_rd_req_id client 0 share at request %0d: got %h expected %h",
                 i, cnt, w0);
        errors++;
      end
    end
  endtask

  task automatic report(input int t, input string name);
    if (timed_out) $display("test %0d %s: stopped by timeout", t, name);
    else $display("test %0d %s: %0d errors", t, name, errors - err_base);
  endtask

  initial begin
    nvdla_core_clk   = 1'b0;
    nvdla_core_rstn  = 1'b0;
    client_req_valid = '0;
    client_req_addr  = '0;
    client_req_size  = '0;
    client_rd_wt     = '0;
    dma_rd_req_ready = 1'b0;
    lfsr      = 32'h6a16_d719;
    run       = 1'b0;
    rdy_rand  = 1'b0;
    timed_out = 1'b0;
    mon_v     = 1'b0;
    mon_r     = 1'b0;
    errors    = 0;
    checks    = 0;
    ord_n     = 0;
    for (int c = 0; c < num_clients; c++) begin
      taken[c]   = 1'b0;
      req_cnt[c] = 0;
      sent[c]    = 0;
      exp_wr[c]  = 0;
      exp_rd[c]  = 0;
    end
    repeat (3) @(negedge nvdla_core_clk);
    nvdla_core_rstn = 1'b1;

    // reset values
    err_base = errors;
    @(negedge nvdla_core_clk);
    checks += 2;
    if (dma_rd_req_valid !== 1'b0) begin
      $display("FAILED dma_rd_req_valid after reset: got %h expected %h", dma_rd_req_valid, 1'b0);
      errors++;
    end
    if (client_req_ready !== '1) begin
      $display("FAILED client_req_ready after reset: got %h expected %h",
               client_req_ready, {num_clients{1'b1}});
      errors++;
    end
    report(1, "reset");

    // table rows, ready held high then random
    for (int t = 2; t <= 3; t++) begin
      start_test(1);
      for (int i = 0; i < 12; i++) begin
        if (int'(tbl[i].test) == t) begin
          add_request(int'(tbl[i].client), tbl[i].addr, int'(tbl[i].size),
                      int'(tbl[i].nchunk));
        end
      end
      run_test(t == 3);
      report(t, (t == 2) ? "split" : "back-pressure");
    end

    // all clients saturated, equal weights
    start_test(1);
    for (int c = 0; c < num_clients; c++) begin
      for (int k = 0; k < 6; k++) begin
        add_request(c, addr_w'((c + 1) << 16) + addr_w'(k * 160), (c + k) % 5, -1);
      end
    end
    run_test(1'b1);
    check_rotation();
    report(4, "fairness");

    // client 0 at weight 3, single atoms
    start_test(3);
    for (int c = 0; c < num_clients; c++) begin
      for (int k = 0; k < ((c == 0) ? 9 : 3); k++) begin
        add_request(c, addr_w'((c + 1) << 17) + addr_w'(k * atom_bytes), 0, 1);
      end
    end
    run_test(1'b0);
    check_weights(3);
    report(5, "weights");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule : tb_rd_ig_top

`default_nettype wire
